// ==== hw/eth_rx_pkg.sv ====
package eth_rx_pkg;

    // Field widths of the receive path.
    localparam int BYTE_W  = 8;
    localparam int MAC_LEN = 6;   // Destination address bytes at the head of a frame.

    // The all-ones destination is accepted by every station.
    localparam logic [MAC_LEN*BYTE_W-1:0] BCAST_MAC = '1;

    // CPU register map.
    localparam logic [15:0] ADDR_CR     = 16'hfb00;
    localparam logic [15:0] ADDR_CNT_LO = 16'hfb02;
    localparam logic [15:0] ADDR_CNT_HI = 16'hfb03;

    // The buffer window covers f000 to f7ff.
    localparam logic [4:0] BUF_BASE_HI = 5'b11110;

    // Bit 0 of the control register reads as full and rearms when written with 1.
    localparam int CR_FULL_BIT = 0;

    typedef enum logic [1:0] {
        RX_ARMED,
        RX_RECV,
        RX_DISCARD,
        RX_FULL
    } rx_state_t;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_BUF,
        SEL_CR,
        SEL_CNT_LO,
        SEL_CNT_HI
    } reg_sel_t;

endpackage

// ==== hw/serial_rx.sv ====
`timescale 1ns/1ns
module serial_rx import eth_rx_pkg::*; #(
    parameter int BUF_AW = 11
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              recv_sck,
    input  logic              recv_mosi,
    input  logic              n_recv_ss,
    input  logic              rx_enable,
    output logic [BYTE_W-1:0] byte_data,
    output logic              byte_stb,
    output logic [BUF_AW:0]   byte_cnt,
    output logic              frame_start,
    output logic              frame_end
);

    localparam int BIT_W = $clog2(BYTE_W);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(BYTE_W - 1);

    logic [1:0]        sck_sync;
    logic [1:0]        mosi_sync;
    logic [1:0]        ss_sync;
    logic              sck_prev;
    logic              ss_prev;
    logic              sck_rise;
    logic              ss_fall;
    logic              ss_rise;
    logic              mosi_bit;
    logic [BIT_W-1:0]  bit_cnt;
    logic [BYTE_W-1:0] shreg;
    logic              shift_en;

    // Bits are taken only inside the select window and while the buffer is not frozen.
    assign shift_en = sck_rise & ~ss_prev & rx_enable;

    // Two-flop synchronizers followed by registered edge pulses.
    always_ff @(posedge clk) begin
        if (n_rst) begin
            sck_sync  <= '0;
            mosi_sync <= '0;
            ss_sync   <= '1;
            sck_prev  <= 1'b0;
            ss_prev   <= 1'b1;
            sck_rise  <= 1'b0;
            ss_fall   <= 1'b0;
            ss_rise   <= 1'b0;
            mosi_bit  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], recv_sck};
            mosi_sync <= {mosi_sync[0], recv_mosi};
            ss_sync   <= {ss_sync[0], n_recv_ss};
            sck_prev  <= sck_sync[1];
            ss_prev   <= ss_sync[1];
            sck_rise  <= sck_sync[1] & ~sck_prev;
            ss_fall   <= ~ss_sync[1] & ss_prev;
            ss_rise   <= ss_sync[1] & ~ss_prev;
            mosi_bit  <= mosi_sync[1];   // Stays aligned with sck_rise.
        end
    end

    always_ff @(posedge clk) begin
        if (n_rst) begin
            bit_cnt     <= '0;
            byte_stb    <= 1'b0;
            byte_cnt    <= '0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            frame_start <= ss_fall;
            frame_end   <= ss_rise;
            byte_stb    <= shift_en && (bit_cnt == BIT_LAST);
            if (ss_fall) begin
                bit_cnt <= '0;
            end else if (shift_en) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // A frame arriving while full must leave the count alone.
            if (frame_start && rx_enable) begin
                byte_cnt <= '0;
            end else if (byte_stb && !byte_cnt[BUF_AW]) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shreg <= {shreg[BYTE_W-2:0], mosi_bit};   // MSB arrives first.
            if (bit_cnt == BIT_LAST) begin
                byte_data <= {shreg[BYTE_W-2:0], mosi_bit};
            end
        end
    end

endmodule

// ==== hw/mac_filter.sv ====
`timescale 1ns/1ns
module mac_filter import eth_rx_pkg::*; #(
    parameter logic [MAC_LEN*BYTE_W-1:0] STATION_MAC = 48'h02_00_00_00_00_01
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic [BYTE_W-1:0] byte_data,
    input  logic              byte_stb,
    input  logic [2:0]        byte_idx,
    input  logic              frame_start,
    input  logic              frame_end,
    output logic              inhibit
);

    logic              st_match;
    logic              bc_match;
    logic              hdr_done;
    logic              inhibit_q;
    logic [2:0]        mac_pos;
    logic [BYTE_W-1:0] st_byte;
    logic              st_hit;
    logic              bc_hit;
    logic              hdr_last;

    // Byte 0 on the wire is the most significant byte of the address.
    assign mac_pos  = (int'(byte_idx) < MAC_LEN) ? 3'(MAC_LEN - 1) - byte_idx : 3'd0;
    assign st_byte  = STATION_MAC[BYTE_W*mac_pos +: BYTE_W];
    assign st_hit   = st_match & (byte_data == st_byte);
    assign bc_hit   = bc_match & (byte_data == BCAST_MAC[BYTE_W-1:0]);   // All bytes are equal.
    assign hdr_last = byte_stb & ~hdr_done & (byte_idx == 3'(MAC_LEN - 1));

    always_ff @(posedge clk) begin
        if (n_rst) begin
            st_match  <= 1'b0;
            bc_match  <= 1'b0;
            hdr_done  <= 1'b0;
            inhibit_q <= 1'b0;
        end else if (frame_start) begin
            st_match  <= 1'b1;
            bc_match  <= 1'b1;
            hdr_done  <= 1'b0;
            inhibit_q <= 1'b0;
        end else begin
            if (byte_stb && !hdr_done) begin
                st_match <= st_hit;
                bc_match <= bc_hit;
            end
            if (hdr_last) begin
                hdr_done  <= 1'b1;
                inhibit_q <= ~(st_hit | bc_hit);
            end
            if (frame_end && !hdr_done) begin
                inhibit_q <= 1'b1;   // Header never completed.
            end
        end
    end

    // A short frame has to be refused in the same cycle that its end is seen.
    assign inhibit = inhibit_q | (frame_end & ~hdr_done);

endmodule

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ns
module frame_buffer import eth_rx_pkg::*; #(
    parameter int BUF_AW = 11
) (
    input  logic              clk,
    input  logic              we,
    input  logic [BUF_AW-1:0] wr_addr,
    input  logic [BYTE_W-1:0] wr_data,
    input  logic [BUF_AW-1:0] rd_addr,
    output logic [BYTE_W-1:0] rd_q
);

    localparam int DEPTH = 2 ** BUF_AW;

    // Simple dual-port byte RAM.
    // The receiver owns the write port and the CPU owns the read port,
    // so both can run in the same cycle.
    logic [BYTE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, one cycle from address to data.
    always_ff @(posedge clk) begin
        rd_q <= mem[rd_addr];
    end

endmodule

// ==== hw/rx_control.sv ====
`timescale 1ns/1ns
module rx_control import eth_rx_pkg::*; (
    input  logic clk,
    input  logic n_rst,
    input  logic frame_start,
    input  logic frame_end,
    input  logic inhibit,
    input  logic rearm,
    input  logic byte_stb,
    input  logic cnt_full,
    output logic rx_enable,
    output logic buf_we,
    output logic buf_full
);

    rx_state_t state;
    rx_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            RX_ARMED: begin
                if (frame_start) begin
                    state_nxt = RX_RECV;
                end
            end
            RX_RECV: begin
                // A frame refused at its very end goes straight back to armed.
                if (frame_end) begin
                    state_nxt = inhibit ? RX_ARMED : RX_FULL;
                end else if (inhibit) begin
                    state_nxt = RX_DISCARD;
                end
            end
            RX_DISCARD: begin
                if (frame_end) begin
                    state_nxt = RX_ARMED;
                end
            end
            RX_FULL: begin
                if (rearm) begin
                    state_nxt = RX_ARMED;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (n_rst) begin
            state <= RX_ARMED;
        end else begin
            state <= state_nxt;
        end
    end

    assign buf_full  = (state == RX_FULL);
    assign rx_enable = ~buf_full;   // Freezes the buffer until rearmed.
    assign buf_we    = byte_stb & (state == RX_RECV) & ~cnt_full;

endmodule

// ==== hw/bus_decode.sv ====
`timescale 1ns/1ns
module bus_decode import eth_rx_pkg::*; #(
    parameter int BUF_AW = 11
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic [15:0]       a,
    input  logic [BYTE_W-1:0] d_in,
    input  logic              n_we,
    input  logic              n_oe,
    input  logic              buf_full,
    input  logic [BUF_AW:0]   byte_cnt,
    input  logic [BYTE_W-1:0] rd_q,
    output logic [BUF_AW-1:0] rd_addr,
    output logic              rearm,
    output logic [BYTE_W-1:0] d_out
);

    reg_sel_t          sel_d;
    reg_sel_t          sel_q;
    logic              n_we_prev;
    logic [15:0]       cnt_ext;
    logic [BYTE_W-1:0] rd_mux;

    // Output enable is folded into the select so an idle bus reads zero.
    always_comb begin
        sel_d = SEL_NONE;
        if (!n_oe) begin
            if (a[15:11] == BUF_BASE_HI) begin
                sel_d = SEL_BUF;
            end else if (a == ADDR_CR) begin
                sel_d = SEL_CR;
            end else if (a == ADDR_CNT_LO) begin
                sel_d = SEL_CNT_LO;
            end else if (a == ADDR_CNT_HI) begin
                sel_d = SEL_CNT_HI;
            end
        end
    end

    assign rd_addr = a[BUF_AW-1:0];   // The RAM registers it alongside sel_q.
    assign cnt_ext = 16'(byte_cnt);

    always_comb begin
        rd_mux = '0;
        case (sel_q)
            SEL_BUF:    rd_mux = rd_q;
            SEL_CR:     rd_mux[CR_FULL_BIT] = buf_full;
            SEL_CNT_LO: rd_mux = cnt_ext[7:0];
            SEL_CNT_HI: rd_mux = cnt_ext[15:8];
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (n_rst) begin
            sel_q     <= SEL_NONE;
            n_we_prev <= 1'b1;
            rearm     <= 1'b0;
            d_out     <= '0;
        end else begin
            sel_q     <= sel_d;
            n_we_prev <= n_we;
            d_out     <= rd_mux;
            // One pulse per write strobe, on its falling edge.
            rearm     <= n_we_prev & ~n_we & (a == ADDR_CR) & d_in[CR_FULL_BIT];
        end
    end

endmodule

// ==== hw/eth_receiver_system.sv ====
`timescale 1ns/1ns
module eth_receiver_system import eth_rx_pkg::*; #(
    parameter int                        BUF_AW      = 11,
    parameter logic [MAC_LEN*BYTE_W-1:0] STATION_MAC = 48'h02_00_00_00_00_01
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              recv_sck,
    input  logic              recv_mosi,
    input  logic              n_recv_ss,
    input  logic [15:0]       a,
    input  logic [BYTE_W-1:0] d_in,
    input  logic              n_we,
    input  logic              n_oe,
    output logic [BYTE_W-1:0] d_out
);

    logic [BYTE_W-1:0] byte_data;
    logic              byte_stb;
    logic [BUF_AW:0]   byte_cnt;
    logic              frame_start;
    logic              frame_end;
    logic              rx_enable;
    logic              inhibit;
    logic              rearm;
    logic              buf_we;
    logic              buf_full;
    logic [BUF_AW-1:0] rd_addr;
    logic [BYTE_W-1:0] rd_q;

    serial_rx #(.BUF_AW(BUF_AW)) u_serial_rx (
        .clk         (clk),
        .n_rst       (n_rst),
        .recv_sck    (recv_sck),
        .recv_mosi   (recv_mosi),
        .n_recv_ss   (n_recv_ss),
        .rx_enable   (rx_enable),
        .byte_data   (byte_data),
        .byte_stb    (byte_stb),
        .byte_cnt    (byte_cnt),
        .frame_start (frame_start),
        .frame_end   (frame_end)
    );

    // The low count bits index the address bytes.
    mac_filter #(.STATION_MAC(STATION_MAC)) u_mac_filter (
        .clk         (clk),
        .n_rst       (n_rst),
        .byte_data   (byte_data),
        .byte_stb    (byte_stb),
        .byte_idx    (byte_cnt[2:0]),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .inhibit     (inhibit)
    );

    rx_control u_rx_control (
        .clk         (clk),
        .n_rst       (n_rst),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .inhibit     (inhibit),
        .rearm       (rearm),
        .byte_stb    (byte_stb),
        .cnt_full    (byte_cnt[BUF_AW]),   // Saturation flag of the count.
        .rx_enable   (rx_enable),
        .buf_we      (buf_we),
        .buf_full    (buf_full)
    );

    frame_buffer #(.BUF_AW(BUF_AW)) u_frame_buffer (
        .clk     (clk),
        .we      (buf_we),
        .wr_addr (byte_cnt[BUF_AW-1:0]),
        .wr_data (byte_data),
        .rd_addr (rd_addr),
        .rd_q    (rd_q)
    );

    bus_decode #(.BUF_AW(BUF_AW)) u_bus_decode (
        .clk      (clk),
        .n_rst    (n_rst),
        .a        (a),
        .d_in     (d_in),
        .n_we     (n_we),
        .n_oe     (n_oe),
        .buf_full (buf_full),
        .byte_cnt (byte_cnt),
        .rd_q     (rd_q),
        .rd_addr  (rd_addr),
        .rearm    (rearm),
        .d_out    (d_out)
    );

endmodule

// ==== bench/eth_rx_assertions.sv ====
`timescale 1ns/1ns
module eth_rx_assertions #(
    parameter int BUF_AW = 11
) (
    input logic            clk,
    input logic            n_rst,
    input logic            byte_stb,
    input logic            buf_full,
    input logic [BUF_AW:0] byte_cnt,
    input logic            rearm
);

    int fail_cnt = 0;

    // A frozen receiver must not deliver bytes.
    no_byte_when_full: assert property (
        @(posedge clk) disable iff (n_rst) !(byte_stb && buf_full)
    ) else begin
        fail_cnt++;
        $error("byte received while the buffer is full");
    end

    cnt_in_range: assert property (
        @(posedge clk) disable iff (n_rst) int'(byte_cnt) <= 2 ** BUF_AW
    ) else begin
        fail_cnt++;
        $error("byte count above buffer depth");
    end

    // Rearm releases the buffer on the next cycle.
    full_clears: assert property (
        @(posedge clk) disable iff (n_rst) (rearm && buf_full) |=> !buf_full
    ) else begin
        fail_cnt++;
        $error("full flag did not fall after rearm");
    end

    rearm_single: assert property (
        @(posedge clk) disable iff (n_rst) rearm |=> !rearm
    ) else begin
        fail_cnt++;
        $error("rearm held longer than one cycle");
    end

endmodule

bind eth_receiver_system eth_rx_assertions #(.BUF_AW(BUF_AW)) u_assertions (
    .clk      (clk),
    .n_rst    (n_rst),
    .byte_stb (byte_stb),
    .buf_full (buf_full),
    .byte_cnt (byte_cnt),
    .rearm    (rearm)
);

// ==== bench/tb_eth_receiver_system.sv ====
`timescale 1ns/1ns
module tb_eth_receiver_system import eth_rx_pkg::*;;

    localparam int          BUF_AW  = 6;
    localparam int          DEPTH   = 2 ** BUF_AW;
    localparam logic [47:0] STATION = 48'h02_00_00_00_00_01;
    localparam logic [47:0] FOREIGN = 48'h02_00_00_00_00_07;
    localparam logic [47:0] BCAST   = 48'hff_ff_ff_ff_ff_ff;
    localparam logic [15:0] BUF_BASE = 16'hf000;

    logic        clk;
    logic        n_rst;
    logic        recv_sck;
    logic        recv_mosi;
    logic        n_recv_ss;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic        n_we;
    logic        n_oe;
    logic [7:0]  d_out;

    int          seed = 32'hdc63;
    int          err_cnt = 0;
    int          assert_cnt;
    logic [7:0]  tx_q[$];       // Bytes of the frame about to be sent.
    logic [7:0]  exp_mem[DEPTH];
    int          exp_len = 0;

    eth_receiver_system #(.BUF_AW(BUF_AW), .STATION_MAC(STATION)) UUT (
        .clk       (clk),
        .n_rst     (n_rst),
        .recv_sck  (recv_sck),
        .recv_mosi (recv_mosi),
        .n_recv_ss (n_recv_ss),
        .a         (a),
        .d_in      (d_in),
        .n_we      (n_we),
        .n_oe      (n_oe),
        .d_out     (d_out)
    );

    always #50 clk = ~clk;

    // Inputs change a little after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Read data is sampled in the third cycle of the access.
    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
        next_cycle;
        a = addr;
        n_oe = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        data = d_out;
        n_oe = 1'b1;
    endtask

    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        next_cycle;
        a = addr;
        d_in = data;
        n_we = 1'b0;
        repeat (2) next_cycle;
        n_we = 1'b1;
        next_cycle;
        d_in = 8'h00;
    endtask

    task automatic check_reg(input string name, input logic [15:0] addr, input logic [7:0] exp);
        logic [7:0] got;
        cpu_read(addr, got);
        check_value(name, got, exp);
    endtask

    task automatic build_frame(input logic [47:0] dest, input int len);
        logic [31:0] rnd;
        int          i;
        tx_q.delete();
        for (i = 0; i < len; i++) begin
            if (i < 6) begin
                tx_q.push_back(dest[47 - 8*i -: 8]);   // Destination goes out first.
            end else begin
                rnd = $random(seed);
                tx_q.push_back(rnd[7:0]);
            end
        end
    endtask

    // Eight clk cycles per serial bit, MSB first.
    task automatic send_frame();
        logic [7:0] b;
        int         k;
        next_cycle;
        n_recv_ss = 1'b0;
        repeat (4) next_cycle;
        foreach (tx_q[i]) begin
            b = tx_q[i];
            for (k = 7; k >= 0; k--) begin
                recv_mosi = b[k];
                recv_sck = 1'b0;
                repeat (4) next_cycle;
                recv_sck = 1'b1;
                repeat (4) next_cycle;
            end
        end
        recv_sck = 1'b0;
        repeat (4) next_cycle;
        n_recv_ss = 1'b1;
        recv_mosi = 1'b0;
        repeat (4) next_cycle;
    endtask

    task automatic wait_full();
        logic [7:0] st;
        int         tries;
        st = 8'h00;
        tries = 0;
        while (!st[0] && tries < 20) begin
            cpu_read(ADDR_CR, st);
            tries++;
        end
        assert (st[0]) else begin
            err_cnt++;
            $display("Timed out waiting for the receiver to report a full buffer");
        end
    endtask

    // The buffer keeps at most DEPTH bytes of the frame just sent.
    task automatic record_expected();
        exp_len = (tx_q.size() < DEPTH) ? tx_q.size() : DEPTH;
        for (int i = 0; i < exp_len; i++) begin
            exp_mem[i] = tx_q[i];
        end
    endtask

    task automatic check_frame();
        string name;
        check_reg("cnt_lo", ADDR_CNT_LO, 8'(exp_len));
        check_reg("cnt_hi", ADDR_CNT_HI, 8'(exp_len >> 8));
        for (int i = 0; i < exp_len; i++) begin
            name = $sformatf("buf[%0d]", i);
            check_reg(name, BUF_BASE + 16'(i), exp_mem[i]);
        end
    endtask

    task automatic receive_accepted(input logic [47:0] dest, input int len);
        build_frame(dest, len);
        send_frame;
        wait_full;
        record_expected;
        check_frame;
        check_reg("status", ADDR_CR, 8'h01);
    endtask

    task automatic rearm_receiver();
        cpu_write(ADDR_CR, 8'h01);
        check_reg("status", ADDR_CR, 8'h00);
    endtask

    initial begin
        clk = 1'b0;
        n_rst = 1'b1;
        recv_sck = 1'b0;
        recv_mosi = 1'b0;
        n_recv_ss = 1'b1;
        a = 16'h0000;
        d_in = 8'h00;
        n_we = 1'b1;
        n_oe = 1'b1;
        repeat (16) @(posedge clk);
        #5;
        n_rst = 1'b0;

        check_reg("status", ADDR_CR, 8'h00);
        check_reg("cnt_lo", ADDR_CNT_LO, 8'h00);
        check_reg("cnt_hi", ADDR_CNT_HI, 8'h00);

        receive_accepted(STATION, 20);
        rearm_receiver;
        receive_accepted(BCAST, 20);
        rearm_receiver;

        build_frame(FOREIGN, 20);   // Dropped by the address filter.
        send_frame;
        repeat (10) next_cycle;
        check_reg("status", ADDR_CR, 8'h00);
        receive_accepted(STATION, 32);

        // The buffer stays frozen while full.
        build_frame(STATION, 16);
        send_frame;
        repeat (10) next_cycle;
        check_reg("status", ADDR_CR, 8'h01);
        check_frame;
        rearm_receiver;
        receive_accepted(STATION, 25);
        rearm_receiver;

        receive_accepted(STATION, 70);   // Count saturates at the depth.

        repeat (4) next_cycle;
        assert_cnt = UUT.u_assertions.fail_cnt;
        $display("Errors: %0d check, %0d assertion", err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/eth_rx_pkg.sv
hw/serial_rx.sv
hw/mac_filter.sv
hw/frame_buffer.sv
hw/rx_control.sv
hw/bus_decode.sv
hw/eth_receiver_system.sv
bench/eth_rx_assertions.sv
bench/tb_eth_receiver_system.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet receiver testbench.

VERILATOR ?= verilator
TOP       ?= tb_eth_receiver_system
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Result: PASSED

SIM_EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_EXE) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
